// File: src/rvIsaPkg.sv
/* RV32I encoding facts used by the pipeline: field positions, opcodes,
   funct codes and the NOP word */
package rvIsaPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regAddr_t;

    // major opcodes, bits [6:0]
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD = 3'b000; // also SUB with F7_SUB
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_SW  = 3'b010;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    // field start bits
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam instr_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

// File: src/rvCorePkg.sv
/* Core-internal codes: ALU operations, forwarding selects and PC constants */
package rvCorePkg;

    typedef logic [2:0] aluOp_t;

    localparam aluOp_t ALU_ADD = 3'd0;
    localparam aluOp_t ALU_SUB = 3'd1;
    localparam aluOp_t ALU_AND = 3'd2;
    localparam aluOp_t ALU_OR  = 3'd3;
    localparam aluOp_t ALU_XOR = 3'd4;
    localparam aluOp_t ALU_SLT = 3'd5; // signed compare

    // where an EX operand comes from
    typedef logic [1:0] fwdSel_t;

    localparam fwdSel_t FWD_RF  = 2'd0; // value read in decode
    localparam fwdSel_t FWD_WB  = 2'd1; // MEM/WB result
    localparam fwdSel_t FWD_MEM = 2'd2; // EX/MEM result

    localparam rvIsaPkg::addr_t PC_STEP  = 32'd4;
    localparam rvIsaPkg::addr_t RESET_PC = 32'd0;

endpackage

// File: src/fetchStage.sv
/* Fetch stage: program counter and the flag that marks when the
   first fetched word has come back */
`timescale 1ns/10ps

module fetchStage (
    input  logic            clk,
    input  logic            rstN,
    output rvIsaPkg::addr_t pc,
    output logic            idValid
);

    // no stalls or redirects, the PC just walks forward
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= rvCorePkg::RESET_PC;
        end else begin
            pc <= pc + rvCorePkg::PC_STEP;
        end
    end

    // instruction memory has one cycle of latency,
    // so the word for RESET_PC is not there in the first cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idValid <= 1'b0;
        end else begin
            idValid <= 1'b1;
        end
    end

endmodule

// File: src/regFile.sv
/* Register file, 32 x 32 bit, x0 reads zero, writes pass through to
   reads in the same cycle */
`timescale 1ns/10ps

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  rvIsaPkg::regAddr_t rs1Addr,
    input  rvIsaPkg::regAddr_t rs2Addr,
    input  rvIsaPkg::regAddr_t wbRd,
    input  rvIsaPkg::word_t    wbResult,
    input  logic               wbRegWrite,
    output rvIsaPkg::word_t    rs1Data,
    output rvIsaPkg::word_t    rs2Data
);

    rvIsaPkg::word_t regs [31:1]; // x0 has no storage

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbRegWrite && (wbRd != '0)) begin
            regs[wbRd] <= wbResult;
        end
    end

    // bypass the write in flight
    assign rs1Data = (rs1Addr == '0) ? '0 :
                     (wbRegWrite && (wbRd == rs1Addr)) ? wbResult : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 :
                     (wbRegWrite && (wbRd == rs2Addr)) ? wbResult : regs[rs2Addr];

endmodule

// File: src/decodeStage.sv
/* Decode stage: control decode, immediate build, register read and
   the ID/EX pipeline register */
`timescale 1ns/10ps

module decodeStage (
    input  logic                clk,
    input  logic                rstN,
    input  rvIsaPkg::instr_t    instr,
    input  logic                idValid,
    input  rvIsaPkg::regAddr_t  wbRd,
    input  rvIsaPkg::word_t     wbResult,
    input  logic                wbRegWrite,
    output rvIsaPkg::regAddr_t  exRs1,
    output rvIsaPkg::regAddr_t  exRs2,
    output rvIsaPkg::regAddr_t  exRd,
    output rvIsaPkg::word_t     exRs1Data,
    output rvIsaPkg::word_t     exRs2Data,
    output rvIsaPkg::word_t     exImm,
    output rvCorePkg::aluOp_t   exAluOp,
    output logic                exUseImm,
    output logic                exRegWrite,
    output logic                exStore
);

    rvIsaPkg::instr_t   idInstr;
    rvIsaPkg::regAddr_t rs1Addr, rs2Addr, rd;
    rvIsaPkg::word_t    rs1Data, rs2Data, imm;
    rvCorePkg::aluOp_t  aluOp;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               useImm, legal, isStore;

    assign idInstr = idValid ? instr : rvIsaPkg::NOP_INSTR; // memory not ready yet
    assign rs1Addr = idInstr[rvIsaPkg::RS1_LSB +: 5];
    assign rs2Addr = idInstr[rvIsaPkg::RS2_LSB +: 5];
    assign rd      = idInstr[rvIsaPkg::RD_LSB +: 5];
    assign funct3  = idInstr[rvIsaPkg::FUNCT3_LSB +: 3];
    assign funct7  = idInstr[rvIsaPkg::FUNCT7_LSB +: 7];

    regFile regFileInst (
        .clk        (clk),
        .rstN       (rstN),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .wbRd       (wbRd),
        .wbResult   (wbResult),
        .wbRegWrite (wbRegWrite),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data)
    );

    always_comb begin
        aluOp   = rvCorePkg::ALU_ADD;
        useImm  = 1'b0;
        legal   = 1'b1;
        isStore = 1'b0;
        imm = {{20{idInstr[31]}}, idInstr[rvIsaPkg::RS2_LSB +: 12]}; // I-type
        case (idInstr[6:0])
            rvIsaPkg::OPCODE_OP, rvIsaPkg::OPCODE_OP_IMM: begin
                useImm = (idInstr[6:0] == rvIsaPkg::OPCODE_OP_IMM);
                case (funct3)
                    rvIsaPkg::F3_ADD: aluOp = rvCorePkg::ALU_ADD;
                    rvIsaPkg::F3_SLT: aluOp = rvCorePkg::ALU_SLT;
                    rvIsaPkg::F3_XOR: aluOp = rvCorePkg::ALU_XOR;
                    rvIsaPkg::F3_OR:  aluOp = rvCorePkg::ALU_OR;
                    rvIsaPkg::F3_AND: aluOp = rvCorePkg::ALU_AND;
                    default:          legal = 1'b0; // shifts, sltu
                endcase
                if (!useImm) begin
                    if ((funct3 == rvIsaPkg::F3_ADD) && (funct7 == rvIsaPkg::F7_SUB)) begin
                        aluOp = rvCorePkg::ALU_SUB;
                    end else if (funct7 != 7'b0) begin
                        legal = 1'b0;
                    end
                end
            end
            rvIsaPkg::OPCODE_STORE: begin
                useImm  = 1'b1; // address = rs1 + S-imm
                isStore = (funct3 == rvIsaPkg::F3_SW);
                legal   = isStore; // byte/half stores dropped
                imm = {{20{idInstr[31]}}, idInstr[rvIsaPkg::FUNCT7_LSB +: 7],
                       idInstr[rvIsaPkg::RD_LSB +: 5]};
            end
            default: legal = 1'b0;
        endcase
    end

    // ID/EX control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exAluOp    <= rvCorePkg::ALU_ADD;
            exUseImm   <= 1'b0;
            exRegWrite <= 1'b0;
            exStore    <= 1'b0;
        end else begin
            exAluOp    <= aluOp;
            exUseImm   <= useImm;
            exRegWrite <= legal && !isStore && (rd != '0); // x0 writes dropped here
            exStore    <= legal && isStore;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        exRs1     <= rs1Addr;
        exRs2     <= rs2Addr;
        exRd      <= rd;
        exRs1Data <= rs1Data;
        exRs2Data <= rs2Data;
        exImm     <= imm;
    end

endmodule

// File: src/executeStage.sv
/* Execute stage: operand forwarding, ALU and the EX/MEM register */
`timescale 1ns/10ps

module executeStage (
    input  logic               clk,
    input  logic               rstN,
    input  rvIsaPkg::regAddr_t exRs1,
    input  rvIsaPkg::regAddr_t exRs2,
    input  rvIsaPkg::regAddr_t exRd,
    input  rvIsaPkg::word_t    exRs1Data,
    input  rvIsaPkg::word_t    exRs2Data,
    input  rvIsaPkg::word_t    exImm,
    input  rvCorePkg::aluOp_t  exAluOp,
    input  logic               exUseImm,
    input  logic               exRegWrite,
    input  logic               exStore,
    input  rvIsaPkg::regAddr_t wbRd,
    input  rvIsaPkg::word_t    wbResult,
    input  logic               wbRegWrite,
    output rvIsaPkg::regAddr_t memRd,
    output rvIsaPkg::word_t    memResult,
    output rvIsaPkg::word_t    memStoreData,
    output logic               memRegWrite,
    output logic               memStore
);

    rvCorePkg::fwdSel_t fwdA, fwdB;
    rvIsaPkg::word_t    opA, rs2Val, opB, aluOut;

    // nearest producer wins
    assign fwdA = (memRegWrite && (memRd == exRs1)) ? rvCorePkg::FWD_MEM :
                  (wbRegWrite && (wbRd == exRs1))   ? rvCorePkg::FWD_WB  : rvCorePkg::FWD_RF;
    assign fwdB = (memRegWrite && (memRd == exRs2)) ? rvCorePkg::FWD_MEM :
                  (wbRegWrite && (wbRd == exRs2))   ? rvCorePkg::FWD_WB  : rvCorePkg::FWD_RF;

    always_comb begin
        case (fwdA)
            rvCorePkg::FWD_MEM: opA = memResult;
            rvCorePkg::FWD_WB:  opA = wbResult;
            default:            opA = exRs1Data;
        endcase
        case (fwdB)
            rvCorePkg::FWD_MEM: rs2Val = memResult;
            rvCorePkg::FWD_WB:  rs2Val = wbResult;
            default:            rs2Val = exRs2Data; // also the store data
        endcase
    end

    assign opB = exUseImm ? exImm : rs2Val;

    always_comb begin
        case (exAluOp)
            rvCorePkg::ALU_SUB: aluOut = opA - opB;
            rvCorePkg::ALU_AND: aluOut = opA & opB;
            rvCorePkg::ALU_OR:  aluOut = opA | opB;
            rvCorePkg::ALU_XOR: aluOut = opA ^ opB;
            rvCorePkg::ALU_SLT: aluOut = {31'b0, $signed(opA) < $signed(opB)};
            default:            aluOut = opA + opB;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memRegWrite <= 1'b0;
            memStore    <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memStore    <= exStore;
        end
    end

    always_ff @(posedge clk) begin
        memRd        <= exRd;
        memResult    <= aluOut;
        memStoreData <= rs2Val;
    end

endmodule

// File: src/memWbStage.sv
/* Memory stage store port and the MEM/WB register feeding writeback */
`timescale 1ns/10ps

module memWbStage (
    input  logic               clk,
    input  logic               rstN,
    input  rvIsaPkg::regAddr_t memRd,
    input  rvIsaPkg::word_t    memResult,
    input  rvIsaPkg::word_t    memStoreData,
    input  logic               memRegWrite,
    input  logic               memStore,
    output rvIsaPkg::word_t    dMemAddr,
    output rvIsaPkg::word_t    dMemData,
    output logic               dMemWrite,
    output rvIsaPkg::regAddr_t wbRd,
    output rvIsaPkg::word_t    wbResult,
    output logic               wbRegWrite
);

    assign dMemAddr  = memResult;    // rs1 + imm from the ALU
    assign dMemData  = memStoreData;
    assign dMemWrite = memStore;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbRegWrite <= 1'b0;
        end else begin
            wbRegWrite <= memRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbRd     <= memRd;
        wbResult <= memResult;
    end

endmodule

// File: src/rvPipe.sv
/* Five-stage RV32I pipeline top, register ALU ops and word stores */
`timescale 1ns/10ps

module rvPipe (
    input  logic             clk,
    input  logic             rstN,
    output rvIsaPkg::addr_t  instrAddr,
    input  rvIsaPkg::instr_t instr,
    output rvIsaPkg::word_t  dMemAddr,
    output rvIsaPkg::word_t  dMemData,
    output logic             dMemWrite
);

    rvIsaPkg::addr_t    pc;
    logic               idValid;
    rvIsaPkg::regAddr_t exRs1, exRs2, exRd, memRd, wbRd;
    rvIsaPkg::word_t    exRs1Data, exRs2Data, exImm;
    rvIsaPkg::word_t    memResult, memStoreData, wbResult;
    rvCorePkg::aluOp_t  exAluOp;
    logic               exUseImm, exRegWrite, exStore;
    logic               memRegWrite, memStore, wbRegWrite;

    assign instrAddr = pc;

    fetchStage fetchStageInst (
        .clk     (clk),
        .rstN    (rstN),
        .pc      (pc),
        .idValid (idValid)
    );

    decodeStage decodeStageInst (
        .clk(clk), .rstN(rstN), .instr(instr), .idValid(idValid),
        .wbRd(wbRd), .wbResult(wbResult), .wbRegWrite(wbRegWrite),
        .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd),
        .exRs1Data(exRs1Data), .exRs2Data(exRs2Data), .exImm(exImm),
        .exAluOp(exAluOp), .exUseImm(exUseImm),
        .exRegWrite(exRegWrite), .exStore(exStore)
    );

    executeStage executeStageInst (
        .clk(clk), .rstN(rstN),
        .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd),
        .exRs1Data(exRs1Data), .exRs2Data(exRs2Data), .exImm(exImm),
        .exAluOp(exAluOp), .exUseImm(exUseImm),
        .exRegWrite(exRegWrite), .exStore(exStore),
        .wbRd(wbRd), .wbResult(wbResult), .wbRegWrite(wbRegWrite),
        .memRd(memRd), .memResult(memResult), .memStoreData(memStoreData),
        .memRegWrite(memRegWrite), .memStore(memStore)
    );

    memWbStage memWbStageInst (
        .clk(clk), .rstN(rstN),
        .memRd(memRd), .memResult(memResult), .memStoreData(memStoreData),
        .memRegWrite(memRegWrite), .memStore(memStore),
        .dMemAddr(dMemAddr), .dMemData(dMemData), .dMemWrite(dMemWrite),
        .wbRd(wbRd), .wbResult(wbResult), .wbRegWrite(wbRegWrite)
    );

endmodule

// File: bench/rvPipe_sva.sv
/* Bound checks on the rvPipe ports: PC stepping and store strobe sanity */
`timescale 1ns/10ps

module rvPipeSva (
    input logic            clk,
    input logic            rstN,
    input rvIsaPkg::addr_t instrAddr,
    input logic            dMemWrite
);

    // one word per cycle, no stalls
    pcStep: assert property (@(posedge clk) disable iff (!rstN)
        $past(rstN) |-> (instrAddr == $past(instrAddr) + 32'd4))
        else $error("instrAddr did not advance by one word");

    strobeKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(dMemWrite))
        else $error("dMemWrite is unknown");

    // pipeline is still filling with NOPs
    quietAfterReset: assert property (@(posedge clk) disable iff (!rstN)
        $rose(rstN) |-> !dMemWrite [*3])
        else $error("store strobe in the first cycles after reset");

endmodule

bind rvPipe rvPipeSva rvPipeSvaInst (
    .clk       (clk),
    .rstN      (rstN),
    .instrAddr (instrAddr),
    .dMemWrite (dMemWrite)
);

// File: bench/rvPipeTb.sv
/* Testbench for the rvPipe pipeline: instruction ROM model, program
   table and checks of every store against hand-computed values */
`timescale 1ns/10ps

module rvPipeTb;

    localparam int STORE_TIMEOUT = 40; // cycles per expected store

    logic             clk = 1'b0;
    logic             rstN;
    rvIsaPkg::addr_t  instrAddr;
    rvIsaPkg::instr_t instr;
    rvIsaPkg::word_t  dMemAddr;
    rvIsaPkg::word_t  dMemData;
    logic             dMemWrite;

    rvIsaPkg::instr_t prog [0:63];
    int               progLen;
    string            expName [0:31];
    rvIsaPkg::addr_t  expAddr [0:31];
    rvIsaPkg::word_t  expData [0:31];
    int               expLen;
    rvIsaPkg::addr_t  lastAddr; // address seen on the previous falling edge

    rvPipe rvPipe_inst (
        .clk       (clk),
        .rstN      (rstN),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dMemAddr  (dMemAddr),
        .dMemData  (dMemData),
        .dMemWrite (dMemWrite)
    );

    always #50 clk = ~clk;

    function automatic rvIsaPkg::instr_t encR(input logic [2:0] f3, input logic [6:0] f7,
                                              input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rvIsaPkg::OPCODE_OP};
    endfunction

    function automatic rvIsaPkg::instr_t encI(input logic [2:0] f3, input int rd,
                                              input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], rvIsaPkg::OPCODE_OP_IMM};
    endfunction

    function automatic rvIsaPkg::instr_t encS(input logic [2:0] f3, input int rs2,
                                              input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], rvIsaPkg::OPCODE_STORE};
    endfunction

    function automatic rvIsaPkg::instr_t romWord(input rvIsaPkg::addr_t addr);
        int idx;
        idx = int'(addr[31:2]);
        if (idx < progLen) begin
            return prog[idx];
        end
        return rvIsaPkg::NOP_INSTR; // past the end of the program
    endfunction

    task automatic addInstr(input rvIsaPkg::instr_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic addNops(input int n);
        for (int i = 0; i < n; i++) begin
            addInstr(rvIsaPkg::NOP_INSTR);
        end
    endtask

    task automatic addStore(input string name, input rvIsaPkg::addr_t a,
                            input rvIsaPkg::word_t d);
        expName[expLen] = name;
        expAddr[expLen] = a;
        expData[expLen] = d;
        expLen++;
    endtask

    task automatic abortRun();
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic loadProgram();
        progLen = 0;
        addInstr(encI(rvIsaPkg::F3_ADD, 1, 0, 100));          // x1 = 100
        addInstr(encI(rvIsaPkg::F3_ADD, 2, 0, -7));           // x2 = -7
        addInstr(encI(rvIsaPkg::F3_ADD, 3, 0, 'h5A));
        addNops(3);
        addInstr(encR(rvIsaPkg::F3_ADD, 7'b0, 4, 1, 2));
        addInstr(encR(rvIsaPkg::F3_ADD, rvIsaPkg::F7_SUB, 5, 2, 1)); // negative
        addInstr(encR(rvIsaPkg::F3_AND, 7'b0, 6, 1, 3));
        addInstr(encR(rvIsaPkg::F3_OR, 7'b0, 7, 1, 3));
        addInstr(encR(rvIsaPkg::F3_XOR, 7'b0, 8, 1, 3));
        addInstr(encR(rvIsaPkg::F3_SLT, 7'b0, 9, 2, 1));      // -7 < 100
        addInstr(encR(rvIsaPkg::F3_SLT, 7'b0, 10, 1, 2));
        addNops(3);
        for (int r = 4; r <= 10; r++) begin
            addInstr(encS(rvIsaPkg::F3_SW, r, 0, 'h100 + 4 * (r - 4)));
        end
        addInstr(encI(rvIsaPkg::F3_ADD, 11, 1, -200));
        addInstr(encI(rvIsaPkg::F3_AND, 12, 3, 'h0F));
        addInstr(encI(rvIsaPkg::F3_OR, 13, 3, 'h100));
        addInstr(encI(rvIsaPkg::F3_XOR, 14, 3, -1));
        addInstr(encI(rvIsaPkg::F3_SLT, 15, 2, -6));
        addInstr(encI(rvIsaPkg::F3_SLT, 16, 1, 50));
        addNops(3);
        for (int r = 11; r <= 16; r++) begin
            addInstr(encS(rvIsaPkg::F3_SW, r, 0, 'h11C + 4 * (r - 11)));
        end
        // back to back dependencies
        addInstr(encI(rvIsaPkg::F3_ADD, 17, 0, 11));
        addInstr(encR(rvIsaPkg::F3_ADD, 7'b0, 18, 17, 17));   // MEM fwd on both
        addInstr(encS(rvIsaPkg::F3_SW, 18, 0, 'h134));        // MEM fwd store data
        addInstr(encR(rvIsaPkg::F3_ADD, rvIsaPkg::F7_SUB, 19, 18, 17)); // WB and pass-through
        addNops(2);
        addInstr(encS(rvIsaPkg::F3_SW, 19, 0, 'h138));
        addInstr(encI(rvIsaPkg::F3_ADD, 20, 0, 'h200));
        addInstr(encS(rvIsaPkg::F3_SW, 17, 20, 0));           // address from MEM fwd
        addInstr(encR(rvIsaPkg::F3_XOR, 7'b0, 21, 20, 17));
        addNops(1);
        addInstr(encS(rvIsaPkg::F3_SW, 21, 20, 4));
        // x0 write, then lui and sb which are not supported
        addInstr(encI(rvIsaPkg::F3_ADD, 0, 0, 55));
        addInstr(encS(rvIsaPkg::F3_SW, 0, 0, 'h140));
        addInstr({20'hABCDE, 5'd1, 7'b0110111});
        addInstr(encS(rvIsaPkg::F3_SW, 1, 0, 'h144));
        addInstr(encS(3'b000, 1, 0, 'h150));
        addNops(3);
        addInstr(encS(rvIsaPkg::F3_SW, 1, 0, 'h148));
    endtask

    task automatic loadExpected();
        expLen = 0;
        addStore("add", 32'h100, 32'h0000_005D);
        addStore("sub negative", 32'h104, 32'hFFFF_FF95);
        addStore("and", 32'h108, 32'h0000_0040);
        addStore("or", 32'h10C, 32'h0000_007E);
        addStore("xor", 32'h110, 32'h0000_003E);
        addStore("slt true", 32'h114, 32'h0000_0001);
        addStore("slt false", 32'h118, 32'h0000_0000);
        addStore("addi", 32'h11C, 32'hFFFF_FF9C);
        addStore("andi", 32'h120, 32'h0000_000A);
        addStore("ori", 32'h124, 32'h0000_015A);
        addStore("xori", 32'h128, 32'hFFFF_FFA5);
        addStore("slti true", 32'h12C, 32'h0000_0001);
        addStore("slti false", 32'h130, 32'h0000_0000);
        addStore("mem forward", 32'h134, 32'h0000_0016);
        addStore("wb forward", 32'h138, 32'h0000_000B);
        addStore("address forward", 32'h200, 32'h0000_000B);
        addStore("wb store data", 32'h204, 32'h0000_020B);
        addStore("x0 write", 32'h140, 32'h0000_0000);
        addStore("lui ignored", 32'h144, 32'h0000_0064);
        addStore("x1 kept", 32'h148, 32'h0000_0064);
    endtask

    // synchronous instruction ROM, one cycle of latency
    always @(negedge clk) begin
        if (rstN) begin
            assert (instrAddr == lastAddr + 32'd4) else begin
                $display("Fail pc sequence: expected %h actual %h", lastAddr + 32'd4, instrAddr);
                abortRun();
            end
            assert (!$isunknown(dMemWrite)) else begin
                $display("dMemWrite is unknown after reset");
                abortRun();
            end
        end else begin
            assert (instrAddr == '0) else begin
                $display("Fail pc reset: expected %h actual %h", 32'd0, instrAddr);
                abortRun();
            end
        end
        instr <= romWord(lastAddr);
        lastAddr = instrAddr;
    end

    initial begin
        int waited;
        rstN     = 1'b0;
        instr    = rvIsaPkg::NOP_INSTR;
        lastAddr = '0;
        loadProgram();
        loadExpected();
        repeat (2) @(negedge clk);
        rstN <= 1'b1;

        for (int i = 0; i < expLen; i++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while ((dMemWrite !== 1'b1) && (waited < STORE_TIMEOUT));
            if (dMemWrite !== 1'b1) begin
                $display("no store seen for %s within %0d cycles", expName[i], STORE_TIMEOUT);
                abortRun();
            end
            assert (dMemAddr == expAddr[i]) else begin
                $display("Fail %s address: expected %h actual %h",
                         expName[i], expAddr[i], dMemAddr);
                abortRun();
            end
            assert (dMemData == expData[i]) else begin
                $display("Fail %s data: expected %h actual %h",
                         expName[i], expData[i], dMemData);
                abortRun();
            end
        end

        // only NOPs remain, so no further stores
        repeat (8) begin
            @(negedge clk);
            assert (dMemWrite == 1'b0) else begin
                $display("unexpected store to %h after the last SW", dMemAddr);
                abortRun();
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: rvPipe.f
src/rvIsaPkg.sv
src/rvCorePkg.sv
src/fetchStage.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memWbStage.sv
src/rvPipe.sv
bench/rvPipe_sva.sv
bench/rvPipeTb.sv

// File: Bender.yml
package:
  name: rvPipe

sources:
  - src/rvIsaPkg.sv
  - src/rvCorePkg.sv
  - src/fetchStage.sv
  - src/regFile.sv
  - src/decodeStage.sv
  - src/executeStage.sv
  - src/memWbStage.sv
  - src/rvPipe.sv
  - target: test
    files:
      - bench/rvPipe_sva.sv
      - bench/rvPipeTb.sv
